//--- source/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// ##############################
	// widths
	// ##############################

	typedef logic [7:0] oam_coord_t;  // y, x, line or pixel number.
	typedef logic [5:0] oam_index_t;  // oam entry 0 to 39.
	typedef logic [3:0] slot_t;       // sprite slot 0 to 9.
	typedef logic [9:0] slot_mask_t;  // one bit per slot.
	typedef logic [3:0] sprite_row_t; // row inside a sprite, 0 to 15.

	// ##############################
	// constants
	// ##############################

	localparam int max_sprites = 10;
	localparam int oam_entries = 40;

	localparam slot_t last_slot = slot_t'(max_sprites - 1);

	// an entry with y value y covers line ly when ly + 16 - y lies in [0, height).
	localparam oam_coord_t y_offset = 8'd16;

	localparam oam_coord_t short_height = 8'd8;
	localparam oam_coord_t tall_height = 8'd16;

	// ##############################
	// scanner states
	// ##############################

	typedef enum logic [1:0] {
		idle,
		scanning,
		full
	} scan_state_t;

endpackage

`default_nettype wire

//--- source/oam_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module oam_scanner import sprite_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        line_start,
	input  oam_coord_t  ly,
	input  logic        tall_sprites,
	input  logic        oam_valid,
	input  oam_index_t  oam_index,
	input  oam_coord_t  oam_y,
	input  oam_coord_t  oam_x,
	output logic        store_en,
	output slot_t       store_slot,
	output oam_coord_t  store_x,
	output oam_index_t  store_index,
	output sprite_row_t store_row
);

	scan_state_t state;
	slot_t       slot_count;
	oam_coord_t  line_offset;
	oam_coord_t  height;
	logic        in_range;
	logic        take_entry;

	// ##############################
	// y range test
	// ##############################

	// the sum wraps in eight bits, so entries below the line land far above the height.
	assign line_offset = ly + y_offset - oam_y;
	assign height = tall_sprites ? tall_height : short_height;
	assign in_range = line_offset < height;

	// a line_start in the same cycle wins over the entry.
	assign take_entry = oam_valid && in_range && (state == scanning) && !line_start;

	// ##############################
	// slot allocation
	// ##############################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			slot_count <= '0;
			store_en <= 1'b0;
		end else if (line_start) begin
			state <= scanning;
			slot_count <= '0;
			store_en <= 1'b0;
		end else begin
			store_en <= take_entry;
			if (take_entry) begin
				slot_count <= slot_count + 1'b1;
				if (slot_count == last_slot)
					state <= full; // tenth sprite taken, the rest of the line is ignored.
			end
		end
	end

	// slots are handed out in arrival order.
	always_ff @(posedge clk) begin
		if (take_entry) begin
			store_slot <= slot_count;
			store_x <= oam_x;
			store_index <= oam_index;
			store_row <= sprite_row_t'(line_offset); // below 16 once in range.
		end
	end

	// ##############################
	// checks
	// ##############################

	slot_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		store_en |-> store_slot < max_sprites
	);

	index_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		oam_valid |-> oam_index < oam_entries
	);

endmodule

`default_nettype wire

//--- source/sprite_x_matchers.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_x_matchers import sprite_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       line_start,
	input  logic       store_en,
	input  slot_t      store_slot,
	input  oam_coord_t store_x,
	input  logic       clear_en,
	input  slot_t      clear_slot,
	input  logic       pixel_step,
	input  logic       pixel_hold,
	output slot_mask_t match_mask
);

	oam_coord_t slot_x [max_sprites];
	slot_mask_t slot_valid;
	slot_mask_t store_sel;
	slot_mask_t clear_sel;
	oam_coord_t pixel_x;

	// one select line per slot for writes and for clears.
	always_comb begin
		for (int i = 0; i < max_sprites; i++) begin
			store_sel[i] = store_en && (store_slot == slot_t'(i));
			clear_sel[i] = clear_en && (clear_slot == slot_t'(i));
		end
	end

	// ##############################
	// slot x registers
	// ##############################

	// each slot has its own clear, line_start drops them all.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid <= '0;
		end else if (line_start) begin
			slot_valid <= '0;
		end else begin
			slot_valid <= (slot_valid | store_sel) & ~clear_sel;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < max_sprites; i++) begin
			if (store_sel[i])
				slot_x[i] <= store_x;
		end
	end

	// ##############################
	// pixel counter and compare
	// ##############################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pixel_x <= '0;
		end else if (line_start) begin
			pixel_x <= '0;
		end else if (pixel_step && !pixel_hold) begin
			pixel_x <= pixel_x + 1'b1; // held while a match is still pending.
		end
	end

	always_comb begin
		for (int i = 0; i < max_sprites; i++)
			match_mask[i] = slot_valid[i] && (slot_x[i] == pixel_x);
	end

	// the priority stage only clears slots it has seen matching.
	clear_valid_slot: assert property (
		@(posedge clk) disable iff (!arst_n)
		clear_en |-> slot_valid[clear_slot]
	);

endmodule

`default_nettype wire

//--- source/sprite_slot_store.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_slot_store import sprite_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        store_en,
	input  slot_t       store_slot,
	input  oam_index_t  store_index,
	input  sprite_row_t store_row,
	input  slot_t       pick_slot,
	output oam_index_t  pick_index,
	output sprite_row_t pick_row
);

	oam_index_t  slot_index [max_sprites];
	sprite_row_t slot_row [max_sprites];

	// oam index and fetch row of every kept sprite.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < max_sprites; i++) begin
				slot_index[i] <= '0;
				slot_row[i] <= '0;
			end
		end else if (store_en) begin
			slot_index[store_slot] <= store_index;
			slot_row[store_slot] <= store_row;
		end
	end

	// read port for the priority stage, no register in the path.
	assign pick_index = slot_index[pick_slot];
	assign pick_row = slot_row[pick_slot];

endmodule

`default_nettype wire

//--- source/sprite_match_priority.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_match_priority import sprite_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        line_start,
	input  slot_mask_t  match_mask,
	input  oam_index_t  pick_index,
	input  sprite_row_t pick_row,
	output slot_t       pick_slot,
	output logic        clear_en,
	output slot_t       clear_slot,
	output logic        pixel_hold,
	output logic        sprite_hit,
	output oam_index_t  sprite_oam_index,
	output sprite_row_t sprite_row
);

	logic  any_match;
	slot_t hit_slot;

	assign any_match = |match_mask;

	// ##############################
	// lowest slot first
	// ##############################

	// walking down means the lowest set bit is written last.
	always_comb begin
		pick_slot = '0;
		for (int i = max_sprites - 1; i >= 0; i--) begin
			if (match_mask[i])
				pick_slot = slot_t'(i);
		end
	end

	// the reported slot drops out at the same edge that registers the hit.
	assign clear_en = any_match;
	assign clear_slot = pick_slot;
	assign pixel_hold = any_match; // keeps pixel_x on the pending x.

	// ##############################
	// hit output
	// ##############################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			sprite_hit <= 1'b0;
		else
			sprite_hit <= any_match && !line_start;
	end

	always_ff @(posedge clk) begin
		if (any_match) begin
			sprite_oam_index <= pick_index;
			sprite_row <= pick_row;
			hit_slot <= pick_slot;
		end
	end

	// a slot that was just reported must already be gone from the matchers.
	no_double_hit: assert property (
		@(posedge clk) disable iff (!arst_n)
		sprite_hit ##1 sprite_hit |-> hit_slot != $past(hit_slot)
	);

endmodule

`default_nettype wire

//--- source/sprite_pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_pipeline_top import sprite_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        line_start,
	input  oam_coord_t  ly,
	input  logic        tall_sprites,
	input  logic        oam_valid,
	input  oam_index_t  oam_index,
	input  oam_coord_t  oam_y,
	input  oam_coord_t  oam_x,
	input  logic        pixel_step,
	output logic        sprite_hit,
	output oam_index_t  sprite_oam_index,
	output sprite_row_t sprite_row,
	output logic        pixel_hold
);

	logic        store_en;
	slot_t       store_slot;
	oam_coord_t  store_x;
	oam_index_t  store_index;
	sprite_row_t store_row;
	slot_mask_t  match_mask;
	logic        clear_en;
	slot_t       clear_slot;
	slot_t       pick_slot;
	oam_index_t  pick_index;
	sprite_row_t pick_row;

	// ##############################
	// scan, match, pick
	// ##############################

	oam_scanner u_scanner (
		.clk(clk), .arst_n(arst_n), .line_start(line_start),
		.ly(ly), .tall_sprites(tall_sprites),
		.oam_valid(oam_valid), .oam_index(oam_index), .oam_y(oam_y), .oam_x(oam_x),
		.store_en(store_en), .store_slot(store_slot), .store_x(store_x),
		.store_index(store_index), .store_row(store_row)
	);

	sprite_x_matchers u_matchers (
		.clk(clk), .arst_n(arst_n), .line_start(line_start),
		.store_en(store_en), .store_slot(store_slot), .store_x(store_x),
		.clear_en(clear_en), .clear_slot(clear_slot),
		.pixel_step(pixel_step), .pixel_hold(pixel_hold),
		.match_mask(match_mask)
	);

	sprite_slot_store u_store (
		.clk(clk), .arst_n(arst_n),
		.store_en(store_en), .store_slot(store_slot),
		.store_index(store_index), .store_row(store_row),
		.pick_slot(pick_slot), .pick_index(pick_index), .pick_row(pick_row)
	);

	sprite_match_priority u_priority (
		.clk(clk), .arst_n(arst_n), .line_start(line_start),
		.match_mask(match_mask), .pick_index(pick_index), .pick_row(pick_row),
		.pick_slot(pick_slot), .clear_en(clear_en), .clear_slot(clear_slot),
		.pixel_hold(pixel_hold), .sprite_hit(sprite_hit),
		.sprite_oam_index(sprite_oam_index), .sprite_row(sprite_row)
	);

endmodule

`default_nettype wire

//--- bench/sprite_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_pipeline_tb import sprite_pkg::*; ();

	localparam string cases_path = "bench/sprite_cases.txt";
	localparam int reset_cycles = 16;
	localparam int cycles_per_record = 200;
	localparam logic [31:0] lfsr_seed = 32'hb65805c1;
	localparam logic [31:0] lfsr_taps = 32'h80200003;

	logic        clk;
	logic        arst_n;
	logic        line_start;
	oam_coord_t  ly;
	logic        tall_sprites;
	logic        oam_valid;
	oam_index_t  oam_index;
	oam_coord_t  oam_y;
	oam_coord_t  oam_x;
	logic        pixel_step;
	logic        sprite_hit;
	oam_index_t  sprite_oam_index;
	sprite_row_t sprite_row;
	logic        pixel_hold;

	logic [31:0] lfsr_state;
	int          record_total;
	oam_index_t  expected_index [$];
	sprite_row_t expected_row [$];

	sprite_pipeline_top UUT (
		.clk(clk), .arst_n(arst_n), .line_start(line_start),
		.ly(ly), .tall_sprites(tall_sprites),
		.oam_valid(oam_valid), .oam_index(oam_index), .oam_y(oam_y), .oam_x(oam_x),
		.pixel_step(pixel_step), .sprite_hit(sprite_hit),
		.sprite_oam_index(sprite_oam_index), .sprite_row(sprite_row),
		.pixel_hold(pixel_hold)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ##############################
	// helpers
	// ##############################

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic check_index(input oam_index_t expected, input oam_index_t actual);
		if (actual !== expected) begin
			$display("Error: %0t ns, sprite_oam_index expected %0d, actual %0d",
				$time, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_row(input sprite_row_t expected, input sprite_row_t actual);
		if (actual !== expected) begin
			$display("Error: %0t ns, sprite_row expected %0d, actual %0d",
				$time, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			$display("Error: %0t ns, %s expected %0d, actual %0d",
				$time, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic require_fields(input int found, input int wanted);
		if (found != wanted) begin
			$display("a record in %s has %0d fields where %0d are needed",
				cases_path, found, wanted);
			abort_run();
		end
	endtask

	// galois form, one shift per bit handed out.
	function automatic logic take_random_bit();
		logic taken;
		taken = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (taken)
			lfsr_state = lfsr_state ^ lfsr_taps;
		return taken;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic count_records();
		int               fd;
		int               code;
		byte              kind;
		logic [8*128-1:0] rest;
		fd = $fopen(cases_path, "r");
		if (fd == 0) begin
			$display("cannot open the cases file %s", cases_path);
			abort_run();
		end
		while ($fscanf(fd, " %c", kind) == 1) begin
			code = $fgets(rest, fd);
			if (kind != "#")
				record_total++;
		end
		$fclose(fd);
	endtask

	task automatic start_line(input oam_coord_t line, input logic tall);
		ly = line;
		tall_sprites = tall; // both stay put for the whole line.
		line_start = 1'b1;
		next_cycle();
		line_start = 1'b0;
	endtask

	task automatic send_entry(input oam_index_t index, input oam_coord_t y, input oam_coord_t x);
		oam_valid = 1'b1;
		oam_index = index;
		oam_y = y;
		oam_x = x;
		next_cycle();
		oam_valid = 1'b0;
	endtask

	// steps counts real advances of pixel_x, so stalls and holds leave the end pixel alone.
	task automatic run_pixels(input int steps);
		int   advanced;
		logic stall;
		advanced = 0;
		while (advanced < steps) begin
			stall = take_random_bit() & take_random_bit(); // idle about one cycle in four.
			pixel_step = !stall;
			@(negedge clk);
			if (pixel_step && !pixel_hold)
				advanced++;
			next_cycle();
		end
		pixel_step = 1'b0;
		do begin
			@(negedge clk);
		end while (pixel_hold || sprite_hit);
		next_cycle();
	endtask

	// ##############################
	// hit monitor and watchdog
	// ##############################

	initial begin
		forever begin
			@(negedge clk);
			if (arst_n && sprite_hit) begin
				if (expected_index.size() == 0) begin
					$display("sprite %0d hit at %0t ns while no hit was expected",
						sprite_oam_index, $time);
					abort_run();
				end else begin
					check_index(expected_index.pop_front(), sprite_oam_index);
					check_row(expected_row.pop_front(), sprite_row);
				end
			end
			if (arst_n && pixel_hold && expected_index.size() == 0) begin
				$display("pixel_hold is high at %0t ns with no hit left to come", $time);
				abort_run();
			end
		end
	end

	initial begin
		wait (record_total > 0);
		repeat (record_total * cycles_per_record + reset_cycles) @(posedge clk);
		$display("the run did not finish within %0d cycles",
			record_total * cycles_per_record + reset_cycles);
		abort_run();
	end

	// ##############################
	// main sequence
	// ##############################

	initial begin
		int               fd;
		int               code;
		int               field_a;
		int               field_b;
		int               field_c;
		byte              kind;
		logic [8*128-1:0] rest;
		arst_n = 1'b0;
		line_start = 1'b0;
		ly = '0;
		tall_sprites = 1'b0;
		oam_valid = 1'b0;
		oam_index = '0;
		oam_y = '0;
		oam_x = '0;
		pixel_step = 1'b0;
		lfsr_state = lfsr_seed;
		record_total = 0;
		count_records();
		repeat (reset_cycles) @(posedge clk);
		#2;
		arst_n = 1'b1;
		next_cycle();
		fd = $fopen(cases_path, "r");
		while ($fscanf(fd, " %c", kind) == 1) begin
			case (kind)
				"#": code = $fgets(rest, fd);
				"L": begin
					code = $fscanf(fd, "%d %d", field_a, field_b);
					require_fields(code, 2);
					start_line(oam_coord_t'(field_a), field_b != 0);
				end
				"O": begin
					code = $fscanf(fd, "%d %d %d", field_a, field_b, field_c);
					require_fields(code, 3);
					send_entry(oam_index_t'(field_a), oam_coord_t'(field_b),
						oam_coord_t'(field_c));
				end
				"R": begin
					code = $fscanf(fd, "%d", field_a);
					require_fields(code, 1);
					run_pixels(field_a);
				end
				"H": begin
					code = $fscanf(fd, "%d %d", field_a, field_b);
					require_fields(code, 2);
					expected_index.push_back(oam_index_t'(field_a));
					expected_row.push_back(sprite_row_t'(field_b));
				end
				"C": begin
					check_count("outstanding expected hits", 0, expected_index.size());
				end
				default: begin
					$display("unknown record kind %c in %s", kind, cases_path);
					abort_run();
				end
			endcase
		end
		$fclose(fd);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/sprite_cases.txt
# L ly tall | O index y x | R pixel steps | H index row | C end of line check
# H records come before the R that produces them, in arrival order.
R 200
C
L 40 0
O 0 56 20
O 1 49 30
O 2 57 25
O 3 48 35
O 4 52 40
H 0 0
H 1 7
H 4 4
R 60
C
L 40 1
O 5 56 10
O 6 41 20
O 7 40 15
O 9 45 50
O 10 49 30
H 5 0
H 6 15
H 10 7
H 9 11
R 80
C
L 100 0
O 11 110 60
O 12 112 20
O 13 109 60
O 14 115 20
O 15 116 90
O 16 113 20
O 17 111 45
O 18 114 60
O 19 110 45
O 20 112 8
O 21 112 5
O 22 112 60
H 20 4
H 12 4
H 14 1
H 16 3
H 17 5
H 19 6
H 11 6
H 13 7
H 18 2
H 15 0
R 120
C
L 60 0
O 23 70 30
O 24 72 100
O 25 76 150
H 23 6
R 50
C
L 60 0
O 26 75 40
H 26 1
R 160
C

//--- list.f
source/sprite_pkg.sv
source/oam_scanner.sv
source/sprite_x_matchers.sv
source/sprite_slot_store.sv
source/sprite_match_priority.sv
source/sprite_pipeline_top.sv
bench/sprite_pipeline_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the sprite pipeline testbench from the project root.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module sprite_pipeline_tb -f list.f -o sprite_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/sprite_sim > sim.log 2>&1

grep -qx "PASS: all tests" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
